/* verilog/tpuCmdPkg.sv */
// Command side types for the scalar execution unit
// Issue numbers wrap at 16, so at most 15 results may be outstanding for
// the age rule to stay meaningful

package tpuCmdPkg;

	localparam int issueWidth = 4;				// Issue counter width
	localparam int indexWidth = 5;				// Register index width

	typedef logic [issueWidth-1:0] issueNo_t;
	typedef logic [indexWidth-1:0] index_t;

	typedef enum logic [1:0] {
		opAlu   = 2'b00,
		opMove  = 2'b01,
		opLoad  = 2'b10,
		opStore = 2'b11
	} opType_t;

	typedef enum logic [1:0] {
		aluAdd = 2'b00,						// Adds src3 as offset too
		aluSub = 2'b01,
		aluAnd = 2'b10,
		aluXor = 2'b11
	} aluOp_t;

	typedef struct packed {
		opType_t  opType;					// Command class
		aluOp_t   aluOp;
		logic     lane;						// 0 even, 1 odd
		index_t   dst;						// Write-back index
		issueNo_t issueNo;
	} command_t;

	// Age of a result relative to the current issue number, modulo 16
	function automatic issueNo_t age(issueNo_t current, issueNo_t issued);
		return current - issued;
	endfunction

endpackage

/* verilog/tpuDataPkg.sv */
// Data side types and queue depths
// Queue depths must be powers of two

package tpuDataPkg;

	localparam int dataWidth = 32;
	localparam int moveDepth = 8;				// Register-move queue
	localparam int lsDepth   = 4;				// Per-lane request queue

	typedef logic [dataWidth-1:0] data_t;

	typedef struct packed {
		tpuCmdPkg::index_t   index;
		tpuCmdPkg::issueNo_t issueNo;
		data_t               data;
	} wbEntry_t;

	typedef struct packed {
		tpuCmdPkg::command_t cmd;
		data_t               addr;			// src1 plus src3
		data_t               stData;			// src2
	} lsReq_t;

endpackage

/* verilog/wbPort.sv */
// One unit's pending result towards the write-back selector
// Source holds pending and entry until take is seen at a clock edge

interface wbPort;

	logic                 pending;
	tpuDataPkg::wbEntry_t entry;
	logic                 take;					// At most one port per cycle

	modport source (
		output pending, entry,
		input  take
	);

	modport sink (
		input  pending, entry,
		output take
	);

endinterface

/* verilog/ringBuffer.sv */
// Circular FIFO, dout shows the head without a read latency
// depth must be a power of two; a push while full is dropped unless a
// pop happens in the same cycle, a pop while empty is ignored

module ringBuffer #(
	parameter type TYPE  = logic [7:0],
	parameter int  depth = 4
)(
	input  logic clock,
	input  logic arstN,
	input  logic push,
	input  logic pop,
	input  TYPE  din,
	output TYPE  dout,
	output logic empty,
	output logic full
);

	TYPE                      mem [depth];
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth)-1:0] wrPtr;
	logic [$clog2(depth):0]   count;
	logic                     doPush;
	logic                     doPop;

	assign doPop  = pop & ~empty;
	assign doPush = push & (~full | doPop);			// Full plus pop frees a slot

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1;		// Wraps at depth
			if (doPop)  rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (doPush) mem[wrPtr] <= din;
	end

	assign dout  = mem[rdPtr];
	assign empty = (count == '0);
	assign full  = (count == ($clog2(depth)+1)'(depth));

endmodule

/* verilog/scalarAlu.sv */
// Two-stage integer ALU, result held in an output register until taken
// A command is only accepted while stall is low and stage one can move on;
// the issuer must not send ALU work while two results are waiting

module scalarAlu (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 stall,
	input  logic                 req,
	input  tpuCmdPkg::command_t  cmd,
	input  tpuDataPkg::data_t    src1,
	input  tpuDataPkg::data_t    src2,
	input  tpuDataPkg::data_t    src3,
	wbPort.source                result,
	output logic                 aluDone
);

	logic                s1Valid;
	tpuCmdPkg::aluOp_t   s1Op;
	tpuCmdPkg::index_t   s1Index;
	tpuCmdPkg::issueNo_t s1IssueNo;
	tpuDataPkg::data_t   s1A;
	tpuDataPkg::data_t   s1B;
	tpuDataPkg::data_t   s1C;
	tpuDataPkg::data_t   aluOut;
	logic                pendingQ;
	logic                advance;

	//////////////////////////////////////////////////////////////////////
	// Stage one, operand capture
	//////////////////////////////////////////////////////////////////////

	assign advance = s1Valid & ~stall & (~pendingQ | result.take);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			s1Valid <= 1'b0;
		end else if (!stall && (!s1Valid || advance)) begin
			s1Valid <= req;
		end
	end

	always_ff @(posedge clock) begin
		if (req && !stall && (!s1Valid || advance)) begin
			s1Op      <= cmd.aluOp;
			s1Index   <= cmd.dst;
			s1IssueNo <= cmd.issueNo;
			s1A       <= src1;
			s1B       <= src2;
			s1C       <= src3;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage two, compute and hold
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		unique case (s1Op)
			tpuCmdPkg::aluAdd: aluOut = s1A + s1B + s1C;	// src3 as offset
			tpuCmdPkg::aluSub: aluOut = s1A - s1B;
			tpuCmdPkg::aluAnd: aluOut = s1A & s1B;
			tpuCmdPkg::aluXor: aluOut = s1A ^ s1B;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			pendingQ <= 1'b0;
			aluDone  <= 1'b0;
		end else begin
			aluDone <= advance;					// Same cycle as pending rises
			if (advance)          pendingQ <= 1'b1;
			else if (result.take) pendingQ <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) result.entry <= '{index: s1Index, issueNo: s1IssueNo, data: aluOut};
	end

	assign result.pending = pendingQ;

endmodule

/* verilog/loadStoreLane.sv */
// One load/store lane with a request queue and one access in flight
// Memory strobes follow ready/grant/endAccess, no address leaves the lane;
// ldStDone pulses for stores only, loads end with their write-back

module loadStoreLane (
	input  logic                clock,
	input  logic                arstN,
	input  logic                stall,
	input  logic                req,
	input  tpuCmdPkg::command_t cmd,
	input  tpuDataPkg::data_t   src1,
	input  tpuDataPkg::data_t   src2,
	input  tpuDataPkg::data_t   src3,
	output logic                ldSt,
	output tpuDataPkg::data_t   stData,
	input  tpuDataPkg::data_t   ldData,
	input  logic                ldReady,
	input  logic                ldGrant,
	input  logic                stReady,
	input  logic                stGrant,
	input  logic                endAccess,
	wbPort.source               result,
	output logic                ldStDone,
	output logic                ldStall,
	output logic                stStall
);

	typedef enum logic [1:0] {sIdle, sRequest, sAccess, sResult} state_t;

	state_t              state;
	tpuDataPkg::lsReq_t  head;
	logic                empty;
	logic                full;
	logic                dispatch;
	logic                granted;
	logic                isLoad;
	tpuCmdPkg::command_t curCmd;
	tpuDataPkg::data_t   curStData;

	ringBuffer #(
		.TYPE  (tpuDataPkg::lsReq_t),
		.depth (tpuDataPkg::lsDepth)
	) reqQueue (
		.clock (clock),
		.arstN (arstN),
		.push  (req),
		.pop   (dispatch),
		.din   ('{cmd: cmd, addr: src1 + src3, stData: src2}),
		.dout  (head),
		.empty (empty),
		.full  (full)
	);

	assign dispatch = (state == sIdle) & ~empty & ~stall;
	assign isLoad   = (curCmd.opType == tpuCmdPkg::opLoad);
	assign granted  = isLoad ? (ldGrant & ldReady) : (stGrant & stReady);

	//////////////////////////////////////////////////////////////////////
	// Access FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state    <= sIdle;
			ldStDone <= 1'b0;
		end else begin
			ldStDone <= 1'b0;
			unique case (state)
				sIdle:    if (dispatch) state <= sRequest;
				sRequest: if (granted) state <= sAccess;	// Held until grant
				sAccess: begin
					if (endAccess) begin
						state    <= isLoad ? sResult : sIdle;
						ldStDone <= ~isLoad;
					end
				end
				sResult:  if (result.take) state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (dispatch) begin
			curCmd    <= head.cmd;
			curStData <= head.stData;
		end
		if (state == sAccess && endAccess)			// Load word sampled here
			result.entry <= '{index: curCmd.dst, issueNo: curCmd.issueNo, data: ldData};
	end

	assign ldSt           = (state == sRequest);
	assign stData         = curStData;
	assign result.pending = (state == sResult);
	assign ldStall        = full;
	assign stStall        = full;

endmodule

/* verilog/writeBackSelect.sv */
// Oldest-first write-back selector with a registered output
// Age ties resolve as move, alu, lane1, lane0

module writeBackSelect (
	input  logic                clock,
	input  logic                arstN,
	input  tpuCmdPkg::issueNo_t issueNo,
	wbPort.sink                 alu,
	wbPort.sink                 lane0,
	wbPort.sink                 lane1,
	wbPort.sink                 move,
	output logic                wbValid,
	output tpuCmdPkg::index_t   wbIndex,
	output tpuDataPkg::data_t   wbData,
	output tpuCmdPkg::issueNo_t wbIssueNo
);

	tpuDataPkg::wbEntry_t cand [4];				// In tie-break order
	logic [3:0]           candPend;
	logic                 found;
	logic [1:0]           sel;
	tpuCmdPkg::issueNo_t  bestAge;

	assign cand[0] = move.entry;
	assign cand[1] = alu.entry;
	assign cand[2] = lane1.entry;
	assign cand[3] = lane0.entry;
	assign candPend = {lane0.pending, lane1.pending, alu.pending, move.pending};

	always_comb begin
		found   = 1'b0;
		sel     = 2'd0;
		bestAge = '0;
		for (int i = 0; i < 4; i++) begin
			// Strictly older replaces, so earlier ports win ties
			if (candPend[i] &&
				(!found || tpuCmdPkg::age(issueNo, cand[i].issueNo) > bestAge)) begin
				found   = 1'b1;
				sel     = 2'(i);
				bestAge = tpuCmdPkg::age(issueNo, cand[i].issueNo);
			end
		end
	end

	assign move.take  = found & (sel == 2'd0);
	assign alu.take   = found & (sel == 2'd1);
	assign lane1.take = found & (sel == 2'd2);
	assign lane0.take = found & (sel == 2'd3);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) wbValid <= 1'b0;
		else        wbValid <= found;				// One cycle after take
	end

	always_ff @(posedge clock) begin
		if (found) begin
			wbIndex   <= cand[sel].index;
			wbData    <= cand[sel].data;
			wbIssueNo <= cand[sel].issueNo;
		end
	end

endmodule

/* verilog/scalarExecUnit.sv */
// Scalar execution unit top level, one write-back per cycle
// Move queue holds 8 entries with no stall flag, so the issuer keeps
// outstanding moves below that; ldStall and stStall cover both lanes

module scalarExecUnit (
	input  logic                clock,
	input  logic                arstN,
	input  logic                stall,
	input  logic                req,
	input  tpuCmdPkg::issueNo_t issueNo,
	input  tpuCmdPkg::command_t cmd,
	input  tpuDataPkg::data_t   src1,
	input  tpuDataPkg::data_t   src2,
	input  tpuDataPkg::data_t   src3,
	output logic [1:0]          ldSt,
	input  tpuDataPkg::data_t   ldData0,
	input  tpuDataPkg::data_t   ldData1,
	output tpuDataPkg::data_t   stData0,
	output tpuDataPkg::data_t   stData1,
	input  logic [1:0]          ldReady,
	input  logic [1:0]          ldGrant,
	input  logic [1:0]          stReady,
	input  logic [1:0]          stGrant,
	input  logic [1:0]          endAccess,
	output logic                wbValid,
	output tpuCmdPkg::index_t   wbIndex,
	output tpuDataPkg::data_t   wbData,
	output tpuCmdPkg::issueNo_t wbIssueNo,
	output logic                aluDone,
	output logic [1:0]          ldStDone,
	output logic                ldStall,
	output logic                stStall
);

	logic       aluReq;
	logic       moveReq;
	logic       isMem;
	logic [1:0] laneReq;
	logic [1:0] laneLdStall;
	logic [1:0] laneStStall;
	logic       moveEmpty;

	wbPort aluWb ();
	wbPort lane0Wb ();
	wbPort lane1Wb ();
	wbPort moveWb ();

	//////////////////////////////////////////////////////////////////////
	// Command class decode
	//////////////////////////////////////////////////////////////////////

	assign aluReq  = req & (cmd.opType == tpuCmdPkg::opAlu);
	assign moveReq = req & (cmd.opType == tpuCmdPkg::opMove);
	assign isMem   = (cmd.opType == tpuCmdPkg::opLoad) | (cmd.opType == tpuCmdPkg::opStore);
	assign laneReq = {req & isMem & cmd.lane, req & isMem & ~cmd.lane};

	assign ldStall = |laneLdStall;
	assign stStall = |laneStStall;

	scalarAlu aluUnit (
		.clock   (clock),
		.arstN   (arstN),
		.stall   (stall),
		.req     (aluReq),
		.cmd     (cmd),
		.src1    (src1),
		.src2    (src2),
		.src3    (src3),
		.result  (aluWb.source),
		.aluDone (aluDone)
	);

	loadStoreLane laneEven (
		.clock     (clock),
		.arstN     (arstN),
		.stall     (stall),
		.req       (laneReq[0]),
		.cmd       (cmd),
		.src1      (src1),
		.src2      (src2),
		.src3      (src3),
		.ldSt      (ldSt[0]),
		.stData    (stData0),
		.ldData    (ldData0),
		.ldReady   (ldReady[0]),
		.ldGrant   (ldGrant[0]),
		.stReady   (stReady[0]),
		.stGrant   (stGrant[0]),
		.endAccess (endAccess[0]),
		.result    (lane0Wb.source),
		.ldStDone  (ldStDone[0]),
		.ldStall   (laneLdStall[0]),
		.stStall   (laneStStall[0])
	);

	loadStoreLane laneOdd (
		.clock     (clock),
		.arstN     (arstN),
		.stall     (stall),
		.req       (laneReq[1]),
		.cmd       (cmd),
		.src1      (src1),
		.src2      (src2),
		.src3      (src3),
		.ldSt      (ldSt[1]),
		.stData    (stData1),
		.ldData    (ldData1),
		.ldReady   (ldReady[1]),
		.ldGrant   (ldGrant[1]),
		.stReady   (stReady[1]),
		.stGrant   (stGrant[1]),
		.endAccess (endAccess[1]),
		.result    (lane1Wb.source),
		.ldStDone  (ldStDone[1]),
		.ldStall   (laneLdStall[1]),
		.stStall   (laneStStall[1])
	);

	//////////////////////////////////////////////////////////////////////
	// Register moves, queued as finished write-back entries
	//////////////////////////////////////////////////////////////////////

	ringBuffer #(
		.TYPE  (tpuDataPkg::wbEntry_t),
		.depth (tpuDataPkg::moveDepth)
	) moveQueue (
		.clock (clock),
		.arstN (arstN),
		.push  (moveReq),
		.pop   (moveWb.take),					// Pops when selected
		.din   ('{index: cmd.dst, issueNo: cmd.issueNo, data: src1}),
		.dout  (moveWb.entry),
		.empty (moveEmpty),
		.full  ()
	);

	assign moveWb.pending = ~moveEmpty;

	writeBackSelect wbSelect (
		.clock     (clock),
		.arstN     (arstN),
		.issueNo   (issueNo),
		.alu       (aluWb.sink),
		.lane0     (lane0Wb.sink),
		.lane1     (lane1Wb.sink),
		.move      (moveWb.sink),
		.wbValid   (wbValid),
		.wbIndex   (wbIndex),
		.wbData    (wbData),
		.wbIssueNo (wbIssueNo)
	);

endmodule

/* tests/scalarExecUnitTb.sv */
// Pattern driven testbench, rows use distinct destination indexes
// Memory model is 16 words, only the low 4 address bits are used

module scalarExecUnitTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int rows = 20;
	localparam int cols = 5;
	localparam int period = 4;
	localparam int resetCycles = 16;
	localparam int holdCycles = 10;				// Stall kept after the stalled rows
	localparam int never = 1 << 30;

	logic clock, arstN, stall, req;
	tpuCmdPkg::issueNo_t issueNo;
	tpuCmdPkg::command_t cmd;
	tpuDataPkg::data_t src1, src2, src3, ldData0, ldData1, stData0, stData1, wbData;
	logic [1:0] ldSt, ldReady, ldGrant, stReady, stGrant, endAccess, ldStDone;
	logic wbValid, aluDone, ldStall, stStall;
	tpuCmdPkg::index_t wbIndex;
	tpuCmdPkg::issueNo_t wbIssueNo;

	logic [31:0] patterns [rows*cols];
	int opOf [rows], aluOf [rows], laneOf [rows], dstOf [rows], flagOf [rows];
	tpuDataPkg::data_t s1Of [rows], s2Of [rows], s3Of [rows], expOf [rows], modelOf [rows];
	int issueOf [rows], issueCyc [rows], readyAt [rows], aluDoneAt [rows];
	bit quiet [rows], finished [rows];
	int rowOfIndex [32];
	int aluRows [$], moveRows [$], laneRows [2][$];
	int pendStore [2], storeDue [2], memPhase [2], memCnt [2];
	tpuDataPkg::data_t memWords [16];
	int cyc, outstanding, aluOutstanding, issueCount, holdCnt, nextRow, unfinished;
	logic stallPrev;
	logic [1:0] ldStPrev;
	tpuCmdPkg::issueNo_t lastIssue;
	logic [15:0] lfsr = 16'd20;

	scalarExecUnit dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #(period/2) clock = ~clock;
	end

	always @(posedge clock) cyc = cyc + 1;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input tpuDataPkg::data_t got,
		input tpuDataPkg::data_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			stopWithFailure("data check failed");
		end
	endtask

	task automatic checkIndex(input string name, input tpuCmdPkg::index_t got,
		input tpuCmdPkg::index_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			stopWithFailure("index check failed");
		end
	endtask

	task automatic checkIssue(input string name, input tpuCmdPkg::issueNo_t got,
		input tpuCmdPkg::issueNo_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			stopWithFailure("issue number check failed");
		end
	endtask

	// Galois LFSR, taps 16,14,13,11
	function automatic logic [15:0] stepLfsr(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	task automatic drawBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = stepLfsr(lfsr);
		end
	endtask

	function automatic tpuDataPkg::data_t aluRule(input int op, input tpuDataPkg::data_t a,
		input tpuDataPkg::data_t b, input tpuDataPkg::data_t c);
		case (op)
			0: return a + b + c;					// Offset only on add
			1: return a - b;
			2: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	function automatic int ageOf(input tpuCmdPkg::issueNo_t cur, input tpuCmdPkg::issueNo_t iss);
		tpuCmdPkg::issueNo_t d;
		d = cur - iss;
		return int'(d);
	endfunction

	function automatic int addressOf(input int r);
		tpuDataPkg::data_t a;
		a = s1Of[r] + s3Of[r];
		return int'(a[3:0]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Memory model, one access per lane
	//////////////////////////////////////////////////////////////////////

	task automatic serveLane(input int n);
		int r;
		int addr;
		int d;
		ldGrant[n] = 1'b0;
		stGrant[n] = 1'b0;
		endAccess[n] = 1'b0;
		if (memPhase[n] == 0 && ldSt[n]) begin
			if (laneRows[n].size() == 0) stopWithFailure("ldSt raised with no request queued");
			drawBits(2, d);						// Grant 0 to 3 cycles later
			memCnt[n] = d;
			memPhase[n] = 1;
		end
		if (memPhase[n] == 1) begin
			if (memCnt[n] == 0) begin
				r = laneRows[n][0];
				if (opOf[r] == 3) stGrant[n] = 1'b1;
				else ldGrant[n] = 1'b1;
				drawBits(1, d);
				memCnt[n] = 1 + d;
				memPhase[n] = 2;
			end else begin
				memCnt[n]--;
			end
		end else if (memPhase[n] == 2) begin
			memCnt[n]--;
			if (memCnt[n] == 0) begin
				r = laneRows[n].pop_front();
				addr = addressOf(r);
				endAccess[n] = 1'b1;
				if (opOf[r] == 3) begin
					memWords[addr] = (n == 0) ? stData0 : stData1;
					pendStore[n] = r;
					storeDue[n] = cyc + 1;
				end else begin
					if (n == 0) ldData0 = memWords[addr];
					else ldData1 = memWords[addr];
					modelOf[r] = memWords[addr];
					readyAt[r] = cyc + 1;			// Pending after this edge
				end
				memPhase[n] = 0;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Issue side
	//////////////////////////////////////////////////////////////////////

	task automatic issueRow(input int r);
		req = 1'b1;
		cmd.opType = tpuCmdPkg::opType_t'(opOf[r][1:0]);
		cmd.aluOp = tpuCmdPkg::aluOp_t'(aluOf[r][1:0]);
		cmd.lane = laneOf[r][0];
		cmd.dst = tpuCmdPkg::index_t'(dstOf[r]);
		cmd.issueNo = tpuCmdPkg::issueNo_t'(issueCount);
		src1 = s1Of[r];
		src2 = s2Of[r];
		src3 = s3Of[r];
		issueOf[r] = issueCount;
		issueCyc[r] = cyc;
		case (opOf[r])
			0: begin
				quiet[r] = (outstanding == 0) && !stall;
				aluRows.push_back(r);
				aluOutstanding++;
			end
			1: begin
				moveRows.push_back(r);
				if (moveRows.size() == 1) readyAt[r] = cyc + 1;
			end
			default: laneRows[laneOf[r]].push_back(r);
		endcase
		outstanding++;
		issueCount++;
	endtask

	task automatic tryIssue(input int r, output bit sent);
		sent = 1'b0;
		if (flagOf[r] != 0 && !stall) begin
			if (outstanding > 0) return;			// Drain before the stall window
			stall = 1'b1;
			holdCnt = 0;
		end
		if (flagOf[r] == 0 && stall) begin
			holdCnt++;
			if (holdCnt >= holdCycles) stall = 1'b0;
			return;
		end
		case (opOf[r])
			0: if (aluOutstanding >= 2 || stall) return;
			1: if (moveRows.size() >= tpuDataPkg::moveDepth) return;
			default: if (ldStall || stStall) return;
		endcase
		if (outstanding >= 12) return;
		issueRow(r);
		sent = 1'b1;
		if (!stall && r + 1 < rows && flagOf[r + 1] != 0) begin
			stall = 1'b1;						// Catches ALU work still in stage one
			holdCnt = 0;
			foreach (aluRows[i]) quiet[aluRows[i]] = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Per-cycle checks at the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic checkCycle();
		int r;
		int c;
		int winAge;
		c = cyc;
		if (wbValid) begin
			r = rowOfIndex[wbIndex];
			if (r < 0 || finished[r] || opOf[r] == 3 || readyAt[r] == never)
				stopWithFailure("write-back for an index with no outstanding result");
			checkIndex("wbIndex", wbIndex, tpuCmdPkg::index_t'(dstOf[r]));
			checkIssue("wbIssueNo", wbIssueNo, tpuCmdPkg::issueNo_t'(issueOf[r]));
			checkData("wbData", wbData, modelOf[r]);
			checkData("wbData", wbData, expOf[r]);
			if (readyAt[r] > c - 1) stopWithFailure("write-back of a result not yet ready");
			winAge = ageOf(lastIssue, tpuCmdPkg::issueNo_t'(issueOf[r]));
			for (int q = 0; q < rows; q++) begin
				if (q != r && !finished[q] && opOf[q] != 3 && readyAt[q] <= c - 1 &&
					ageOf(lastIssue, tpuCmdPkg::issueNo_t'(issueOf[q])) > winAge)
					stopWithFailure("write-back skipped an older ready result");
			end
			if (opOf[r] == 0 && quiet[r] && c != aluDoneAt[r] + 1)
				stopWithFailure("wbValid did not follow aluDone by one cycle");
			finished[r] = 1'b1;
			outstanding--;
			if (opOf[r] == 0) aluOutstanding--;
			if (opOf[r] == 1) begin
				if (moveRows.pop_front() != r) stopWithFailure("moves written back out of order");
				if (moveRows.size() > 0)		// Next head shows this cycle
					readyAt[moveRows[0]] = (issueCyc[moveRows[0]] + 1 > c) ?
						issueCyc[moveRows[0]] + 1 : c;
			end
		end
		if (aluDone) begin
			if (stallPrev) stopWithFailure("aluDone rose while stall was held");
			if (aluRows.size() == 0) stopWithFailure("aluDone with no ALU command in flight");
			r = aluRows.pop_front();
			readyAt[r] = c;
			aluDoneAt[r] = c;
			if (quiet[r] && c != issueCyc[r] + 2) stopWithFailure("aluDone not 2 cycles after req");
		end
		for (int n = 0; n < 2; n++) begin
			if (ldStDone[n]) begin
				if (pendStore[n] < 0 || storeDue[n] != c)
					stopWithFailure("ldStDone without a finished store on that lane");
				r = pendStore[n];
				checkData("stored memory word", memWords[addressOf(r)], expOf[r]);
				finished[r] = 1'b1;
				outstanding--;
				pendStore[n] = -1;
			end else if (pendStore[n] >= 0 && storeDue[n] <= c) begin
				stopWithFailure("store finished without ldStDone");
			end
			if (stallPrev && ldSt[n] && !ldStPrev[n]) stopWithFailure("ldSt rose while stall was held");
			ldStPrev[n] = ldSt[n];
		end
		stallPrev = stall;
		lastIssue = issueNo;
	endtask

	always @(negedge clock) begin
		if (arstN) checkCycle();
	end

	initial begin
		#((resetCycles + 40 * rows) * period);
		stopWithFailure("timeout, results still outstanding");
	end

	initial begin
		bit sent;
		arstN = 1'b0;
		stall = 1'b0;
		req = 1'b0;
		issueNo = '0;
		cmd = '0;
		src1 = '0;
		src2 = '0;
		src3 = '0;
		ldData0 = '0;
		ldData1 = '0;
		ldReady = 2'b11;						// Memory always ready
		stReady = 2'b11;
		ldGrant = '0;
		stGrant = '0;
		endAccess = '0;
		cyc = 0;
		stallPrev = 1'b0;
		ldStPrev = '0;
		lastIssue = '0;
		for (int a = 0; a < 16; a++) memWords[a] = tpuDataPkg::data_t'(a * 3);
		for (int i = 0; i < 32; i++) rowOfIndex[i] = -1;
		for (int n = 0; n < 2; n++) begin
			pendStore[n] = -1;
			memPhase[n] = 0;
		end
		$readmemh("tests/execPatterns.txt", patterns);
		for (int r = 0; r < rows; r++) begin
			flagOf[r] = int'(patterns[r*cols][20]);
			opOf[r] = int'(patterns[r*cols][17:16]);
			aluOf[r] = int'(patterns[r*cols][13:12]);
			laneOf[r] = int'(patterns[r*cols][8]);
			dstOf[r] = int'(patterns[r*cols][4:0]);
			s1Of[r] = patterns[r*cols+1];
			s2Of[r] = patterns[r*cols+2];
			s3Of[r] = patterns[r*cols+3];
			expOf[r] = patterns[r*cols+4];
			readyAt[r] = never;
			if (rowOfIndex[dstOf[r]] >= 0) stopWithFailure("pattern file reuses a destination index");
			rowOfIndex[dstOf[r]] = r;
			if (opOf[r] == 0) modelOf[r] = aluRule(aluOf[r], s1Of[r], s2Of[r], s3Of[r]);
			if (opOf[r] == 1) modelOf[r] = s1Of[r];	// Move copies src1
		end
		repeat (resetCycles) @(posedge clock);
		#0.5;
		arstN = 1'b1;
		if (wbValid !== 1'b0 || ldSt !== 2'b00 || ldStall !== 1'b0 || stStall !== 1'b0 ||
			aluDone !== 1'b0 || ldStDone !== 2'b00)
			stopWithFailure("outputs not cleared by reset");
		nextRow = 0;
		while (nextRow < rows || outstanding > 0) begin
			@(posedge clock);
			#0.5;
			req = 1'b0;
			issueNo = tpuCmdPkg::issueNo_t'(issueCount);
			serveLane(0);
			serveLane(1);
			if (nextRow < rows) begin
				tryIssue(nextRow, sent);
				if (sent) nextRow++;
			end
		end
		repeat (4) @(posedge clock);
		unfinished = 0;
		for (int r = 0; r < rows; r++) if (!finished[r]) unfinished++;
		if (unfinished == 0 && !wbValid) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stopWithFailure("results missing or extra write-back at the end");
		end
	end

endmodule

/* scalarExecUnit.f */
verilog/tpuCmdPkg.sv
verilog/tpuDataPkg.sv
verilog/wbPort.sv
verilog/ringBuffer.sv
verilog/scalarAlu.sv
verilog/loadStoreLane.sv
verilog/writeBackSelect.sv
verilog/scalarExecUnit.sv
tests/scalarExecUnitTb.sv

/* Makefile */
# Verilator build and run for the scalar execution unit testbench

VERILATOR ?= verilator
TOP       ?= scalarExecUnitTb
FILELIST  ?= scalarExecUnit.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/execPatterns.txt */
// ctrl: bit 20 issue under stall, 17:16 class, 13:12 ALU op, 8 lane, 7:0 dst
// then src1 src2 src3 and expected write-back data (store rows: memory word)
00000001 00000010 00000020 00000003 00000033
00001002 00000100 00000001 00000000 000000FF
00002003 F0F0F0F0 FF00FF00 00000000 F000F000
00003004 12345678 FFFFFFFF 00000000 EDCBA987
00010005 DEADBEEF 00000000 00000000 DEADBEEF
00020006 00000002 00000000 00000003 0000000F
00020107 00000008 00000000 00000000 00000018
00030008 00000004 CAFE0001 00000000 CAFE0001
00020009 00000004 00000000 00000000 CAFE0001
0001000A 00000077 00000000 00000000 00000077
0000000B 00000001 00000002 00000003 00000006
0003010C 0000000A 5A5A5A5A 00000001 5A5A5A5A
0011000D 0000ABCD 00000000 00000000 0000ABCD
0012010E 0000000B 00000000 00000000 5A5A5A5A
0013000F 00000001 11112222 00000001 11112222
00120010 00000002 00000000 00000000 11112222
00003011 0000FFFF 00FF00FF 00000000 00FFFF00
00020112 0000000E 00000000 00000001 0000002D
00010013 00000013 00000000 00000000 00000013
00001014 00000005 00000007 00000000 FFFFFFFE
